//--- hw/chan_agg_defs.svh
`ifndef CHAN_AGG_DEFS_SVH
`define CHAN_AGG_DEFS_SVH

`default_nettype none

// ==========================================================================
// Aggregator sizing
// ==========================================================================

`define CHAN_AGG_WORD_W     16        // Data word width
`define CHAN_AGG_NUM_CHAN   4         // Producer channels

// Per-channel buffer
`define CHAN_AGG_DEPTH      16        // Words per buffer, power of two
`define CHAN_AGG_THRESHOLD  4         // Fill level before a buffer offers data

// Arbitration
`define CHAN_AGG_BURST_LEN  4         // Max words per grant

`default_nettype wire

`endif

//--- hw/chan_agg_pkg.sv
`default_nettype none

`include "chan_agg_defs.svh"

package chan_agg_pkg;

   // ========================================================================
   // Data types
   // ========================================================================

   typedef logic [`CHAN_AGG_WORD_W-1:0] word_t;            // One stream word

   typedef logic [1:0] chan_id_t;                           // Channel index

   // One word per channel, lane i in slice i
   typedef word_t [`CHAN_AGG_NUM_CHAN-1:0] chan_words_t;

   // ========================================================================
   // Arbiter FSM
   // ========================================================================

   typedef enum logic
   {
      ARB_IDLE,                                              // Searching for a requester
      ARB_BURST                                              // Forwarding granted lane
   } arb_state_t;

endpackage

`default_nettype wire

//--- hw/stream_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module stream_fifo
   import chan_agg_pkg::*;
#(
   parameter int DEPTH     = 16,
   parameter int THRESHOLD = 4
)
(
   input  wire        clk,
   input  wire        rst,
   input  wire        in_valid,
   input  wire word_t in_data,
   output logic       in_ready,
   output logic       out_valid,
   output word_t      out_data,
   input  wire        out_ready
);

   localparam int CW = $clog2(DEPTH);

   // ========================================================================
   // Storage and pointers
   // ========================================================================

   word_t         mem [DEPTH];
   logic [CW:0]   wr_ptr;                 // Extra MSB is the wrap bit
   logic [CW:0]   rd_ptr;
   logic [CW:0]   fill;

   logic          ptr_lo_eq;
   logic          wrap_eq;
   logic          full;
   logic          empty;
   logic          thr_reached;
   logic          released;               // Threshold seen since the last drain
   logic          do_write;
   logic          do_read;

   assign ptr_lo_eq = wr_ptr[CW-1:0] == rd_ptr[CW-1:0];
   assign wrap_eq   = wr_ptr[CW] == rd_ptr[CW];
   assign full      = ptr_lo_eq & ~wrap_eq;
   assign empty     = ptr_lo_eq & wrap_eq;

   assign fill        = wr_ptr - rd_ptr;   // Wrap bit makes this exact
   assign thr_reached = fill >= (CW+1)'(THRESHOLD);

   // Words are held back until the threshold is reached, then drained to empty
   assign out_valid = ~empty & (thr_reached | released);

   assign do_read  = out_valid & out_ready;
   assign in_ready = ~full | do_read;      // Full buffer takes a word only on a pop
   assign do_write = in_valid & in_ready;

   assign out_data = mem[rd_ptr[CW-1:0]];  // First word falls through

   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr[CW-1:0]] <= in_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         released <= 1'b0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
         if (thr_reached)
            released <= 1'b1;
         else if (empty)
            released <= 1'b0;
      end
   end

   // ========================================================================
   // Checks
   // ========================================================================

   // A full buffer's write pointer moves only when a word is popped
   a_no_overflow : assert property (
      @(posedge clk) disable iff (rst)
      (full && !(out_valid && out_ready)) |=> (wr_ptr == $past(wr_ptr))
   );

   // Fill level never goes past the buffer size
   a_fill_bound : assert property (
      @(posedge clk) disable iff (rst)
      full |=> (fill <= (CW+1)'(DEPTH))
   );

endmodule

`default_nettype wire

//--- hw/burst_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "chan_agg_defs.svh"

module burst_arbiter
   import chan_agg_pkg::*;
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire [`CHAN_AGG_NUM_CHAN-1:0]      fifo_valid,
   input  wire chan_words_t                  fifo_data,
   output logic [`CHAN_AGG_NUM_CHAN-1:0]     fifo_ready,
   output logic                              arb_valid,
   output word_t                             arb_data,
   output chan_id_t                          arb_chan,
   input  wire                               stage_ready
);

   localparam int NCH   = `CHAN_AGG_NUM_CHAN;
   localparam int BL    = `CHAN_AGG_BURST_LEN;
   localparam int CNT_W = $clog2(BL + 1);

   // ========================================================================
   // State
   // ========================================================================

   arb_state_t    state;
   chan_id_t      grant_chan;              // Also the last-granted pointer
   logic [CNT_W-1:0] burst_cnt;            // Transfers in the current burst

   logic          pick_found;
   chan_id_t      pick_chan;
   logic          xfer;
   logic          last_beat;
   logic          lane_dry;

   // Round-robin search, starting one past the last grant
   always_comb
   begin
      chan_id_t idx;

      pick_found = 1'b0;
      pick_chan  = grant_chan;
      for (int k = 1; k <= NCH; k++)
      begin
         idx = grant_chan + chan_id_t'(k);
         if (!pick_found && fifo_valid[idx])
         begin
            pick_found = 1'b1;
            pick_chan  = idx;
         end
      end
   end

   // ========================================================================
   // Forward path
   // ========================================================================

   always_comb
   begin
      fifo_ready = '0;
      arb_valid  = 1'b0;
      arb_data   = fifo_data[grant_chan];
      arb_chan   = grant_chan;
      if (state == ARB_BURST)
      begin
         arb_valid              = fifo_valid[grant_chan];
         fifo_ready[grant_chan] = stage_ready;
      end
   end

   assign xfer      = arb_valid & stage_ready;
   assign last_beat = xfer && (burst_cnt == CNT_W'(BL - 1));
   assign lane_dry  = ~fifo_valid[grant_chan];   // Drained or under threshold

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= ARB_IDLE;
         grant_chan <= chan_id_t'(NCH - 1);      // First search starts at 0
         burst_cnt  <= '0;
      end
      else
      begin
         case (state)
            ARB_IDLE:
            begin
               if (pick_found)
               begin
                  state      <= ARB_BURST;
                  grant_chan <= pick_chan;
                  burst_cnt  <= '0;
               end
            end
            ARB_BURST:
            begin
               if (xfer)
                  burst_cnt <= burst_cnt + 1'b1;
               if (lane_dry || last_beat)
                  state <= ARB_IDLE;
            end
            default:
               state <= ARB_IDLE;
         endcase
      end
   end

   // ========================================================================
   // Checks
   // ========================================================================

   a_one_ready : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(fifo_ready)
   );

   // A burst never runs past its length before the FSM drops back to idle
   a_burst_len : assert property (
      @(posedge clk) disable iff (rst)
      (state == ARB_BURST) |-> (burst_cnt < CNT_W'(BL))
   );

endmodule

`default_nettype wire

//--- hw/out_stage.sv
`timescale 1ns/100ps
`default_nettype none

module out_stage
   import chan_agg_pkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           arb_valid,
   input  wire word_t    arb_data,
   input  wire chan_id_t arb_chan,
   output logic          stage_ready,
   output logic          out_valid,
   output word_t         out_data,
   output chan_id_t      out_chan,
   input  wire           out_ready
);

   // Second entry catches the word in flight when the output stalls
   logic          skid_valid;
   word_t         skid_data;
   chan_id_t      skid_chan;

   logic          in_xfer;
   logic          main_load;

   assign stage_ready = ~skid_valid;      // Straight from a flop
   assign in_xfer     = arb_valid & stage_ready;
   assign main_load   = ~out_valid | out_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (main_load)
      begin
         out_valid  <= skid_valid | in_xfer;
         skid_valid <= 1'b0;
      end
      else if (in_xfer)
         skid_valid <= 1'b1;              // Output stalled, park the word
   end

   always_ff @(posedge clk)
   begin
      if (main_load)
      begin
         if (skid_valid)
         begin
            out_data <= skid_data;        // Older word goes first
            out_chan <= skid_chan;
         end
         else if (in_xfer)
         begin
            out_data <= arb_data;
            out_chan <= arb_chan;
         end
      end
      else if (in_xfer)
      begin
         skid_data <= arb_data;
         skid_chan <= arb_chan;
      end
   end

   a_out_stable : assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_chan))
   );

endmodule

`default_nettype wire

//--- hw/chan_agg.sv
`timescale 1ns/100ps
`default_nettype none

`include "chan_agg_defs.svh"

module chan_agg
   import chan_agg_pkg::*;
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire [`CHAN_AGG_NUM_CHAN-1:0]      in_valid,
   input  wire chan_words_t                  in_data,
   output logic [`CHAN_AGG_NUM_CHAN-1:0]     in_ready,
   output logic                              out_valid,
   output word_t                             out_data,
   output chan_id_t                          out_chan,
   input  wire                               out_ready
);

   // ========================================================================
   // Buffer to arbiter lanes
   // ========================================================================

   logic [`CHAN_AGG_NUM_CHAN-1:0]   fifo_valid;
   chan_words_t                     fifo_data;
   logic [`CHAN_AGG_NUM_CHAN-1:0]   fifo_ready;

   // Arbiter to output stage
   logic          arb_valid;
   word_t         arb_data;
   chan_id_t      arb_chan;
   logic          stage_ready;

   stream_fifo #(.DEPTH(`CHAN_AGG_DEPTH), .THRESHOLD(`CHAN_AGG_THRESHOLD)) fifo0 (
      .clk(clk), .rst(rst),
      .in_valid(in_valid[0]), .in_data(in_data[0]), .in_ready(in_ready[0]),
      .out_valid(fifo_valid[0]), .out_data(fifo_data[0]), .out_ready(fifo_ready[0])
   );

   stream_fifo #(.DEPTH(`CHAN_AGG_DEPTH), .THRESHOLD(`CHAN_AGG_THRESHOLD)) fifo1 (
      .clk(clk), .rst(rst),
      .in_valid(in_valid[1]), .in_data(in_data[1]), .in_ready(in_ready[1]),
      .out_valid(fifo_valid[1]), .out_data(fifo_data[1]), .out_ready(fifo_ready[1])
   );

   stream_fifo #(.DEPTH(`CHAN_AGG_DEPTH), .THRESHOLD(`CHAN_AGG_THRESHOLD)) fifo2 (
      .clk(clk), .rst(rst),
      .in_valid(in_valid[2]), .in_data(in_data[2]), .in_ready(in_ready[2]),
      .out_valid(fifo_valid[2]), .out_data(fifo_data[2]), .out_ready(fifo_ready[2])
   );

   stream_fifo #(.DEPTH(`CHAN_AGG_DEPTH), .THRESHOLD(`CHAN_AGG_THRESHOLD)) fifo3 (
      .clk(clk), .rst(rst),
      .in_valid(in_valid[3]), .in_data(in_data[3]), .in_ready(in_ready[3]),
      .out_valid(fifo_valid[3]), .out_data(fifo_data[3]), .out_ready(fifo_ready[3])
   );

   // ========================================================================
   // Arbitration and output
   // ========================================================================

   burst_arbiter arb0 (
      .clk(clk), .rst(rst),
      .fifo_valid(fifo_valid), .fifo_data(fifo_data), .fifo_ready(fifo_ready),
      .arb_valid(arb_valid), .arb_data(arb_data), .arb_chan(arb_chan),
      .stage_ready(stage_ready)
   );

   out_stage ostage0 (
      .clk(clk), .rst(rst),
      .arb_valid(arb_valid), .arb_data(arb_data), .arb_chan(arb_chan),
      .stage_ready(stage_ready),
      .out_valid(out_valid), .out_data(out_data), .out_chan(out_chan),
      .out_ready(out_ready)
   );

endmodule

`default_nettype wire

//--- verif/chan_agg_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "chan_agg_defs.svh"

module chan_agg_tb
   import chan_agg_pkg::*;
;
   localparam int NCH     = `CHAN_AGG_NUM_CHAN;
   localparam int TIMEOUT = 3000;           // Cycles per wait loop

   logic                  clk;
   logic                  rst;
   logic [NCH-1:0]        in_valid;
   chan_words_t           in_data;
   wire  [NCH-1:0]        in_ready;
   wire                   out_valid;
   word_t                 out_data;
   chan_id_t              out_chan;
   logic                  out_ready;

   integer    seed;
   int        err_count;
   int        test_count;
   int        rdy_mode;                      // 0 low, 1 high, 2 random
   word_t     src_q [NCH][$];                // Words waiting to be driven
   word_t     exp_q [NCH][$];                // Accepted words, in order
   word_t     got_data [$];
   chan_id_t  got_chan [$];
   int        acc_cnt [NCH];
   int        out_cnt [NCH];
   chan_id_t  run_chan;
   int        run_len;
   int        hold_len;

   chan_agg dut0 (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
      .out_valid(out_valid), .out_data(out_data), .out_chan(out_chan),
      .out_ready(out_ready)
   );

   always #4 clk = ~clk;

   // ========================================================================
   // Monitor of input handshakes, output words and burst lengths
   // ========================================================================

   always @(posedge clk)
   begin
      logic other_full;

      if (!rst)
      begin
         for (int c = 0; c < NCH; c++)
            if (in_valid[c] && in_ready[c] && src_q[c].size() > 0)
            begin
               exp_q[c].push_back(src_q[c].pop_front());
               acc_cnt[c]++;
            end
         if (out_valid && out_ready)
         begin
            got_data.push_back(out_data);
            got_chan.push_back(out_chan);
            out_cnt[out_chan]++;
            run_len  = (run_len > 0 && out_chan == run_chan) ? run_len + 1 : 1;
            run_chan = out_chan;
            other_full = 1'b0;
            // Margin of two words for the output stage
            for (int c = 0; c < NCH; c++)
               if (c != out_chan && acc_cnt[c] - out_cnt[c] >= `CHAN_AGG_THRESHOLD + 2)
                  other_full = 1'b1;
            if (run_len == 1 || !other_full)
               hold_len = 0;
            if (other_full)
               hold_len++;
            if (hold_len == `CHAN_AGG_BURST_LEN + 4)
            begin
               $display("Burst from channel %0d ran on while another channel waited, t=%0t",
                        out_chan, $time);
               err_count++;
            end
         end
      end
   end

   // ========================================================================
   // Driver and compare tasks
   // ========================================================================

   task automatic step();
      @(negedge clk);
      for (int c = 0; c < NCH; c++)
      begin
         in_valid[c] = src_q[c].size() > 0;
         in_data[c]  = (src_q[c].size() > 0) ? src_q[c][0] : '0;
      end
      case (rdy_mode)
         0:       out_ready = 1'b0;
         1:       out_ready = 1'b1;
         default: out_ready = $random(seed) & 1;
      endcase
   endtask

   task automatic apply_reset();
      rst      = 1'b1;
      rdy_mode = 1;
      for (int c = 0; c < NCH; c++)
      begin
         src_q[c].delete();
         exp_q[c].delete();
         acc_cnt[c] = 0;
         out_cnt[c] = 0;
      end
      got_data.delete();
      got_chan.delete();
      run_len  = 0;
      hold_len = 0;
      repeat (4) step();
      rst = 1'b0;
   endtask

   task automatic check_word(string name, word_t exp, word_t act);
      if (exp !== act)
      begin
         $display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_chan(string name, chan_id_t exp, chan_id_t act);
      if (exp !== act)
      begin
         $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (exp != act)
      begin
         $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic wait_outputs(int n);
      int cyc;

      cyc = 0;
      while (got_data.size() < n && cyc < TIMEOUT)
      begin
         step();
         cyc++;
      end
      if (got_data.size() < n)
      begin
         $display("Timed out waiting for %0d output words, saw %0d, arbiter in %s",
                  n, got_data.size(), dut0.arb0.state.name());
         err_count++;
      end
   endtask

   task automatic wait_src_empty();
      int cyc;
      int left;

      cyc  = 0;
      left = 1;
      while (left > 0 && cyc < TIMEOUT)
      begin
         step();
         cyc++;
         left = 0;
         for (int c = 0; c < NCH; c++)
            left += src_q[c].size();
      end
      if (left > 0)
      begin
         $display("Timed out with %0d input words never accepted", left);
         err_count++;
      end
   endtask

   // Every output word must be the next accepted word of its channel
   task automatic check_log();
      word_t exp;

      for (int i = 0; i < got_data.size(); i++)
      begin
         exp = (exp_q[got_chan[i]].size() > 0) ? exp_q[got_chan[i]].pop_front() : 'x;
         check_word($sformatf("out_data[%0d]", i), exp, got_data[i]);
      end
      for (int c = 0; c < NCH; c++)
         check_count($sformatf("words left in channel %0d", c), 0, exp_q[c].size());
   endtask

   task automatic finish_test(string name, int errs_before);
      test_count++;
      $display("%-22s %s", name, (err_count == errs_before) ? "ok" : "failed");
   endtask

   // ========================================================================
   // Tests
   // ========================================================================

   task automatic test_reset();
      int e;

      e = err_count;
      apply_reset();
      check_count("out_valid", 0, out_valid);
      check_count("in_ready", NCH, $countones(in_ready));
      finish_test("reset state", e);
   endtask

   task automatic test_single();
      int e;

      e = err_count;
      apply_reset();
      repeat (12)
         src_q[1].push_back(word_t'($random(seed)));
      wait_outputs(12);
      foreach (got_chan[i])
         check_chan($sformatf("out_chan[%0d]", i), 2'd1, got_chan[i]);
      check_log();
      finish_test("single channel", e);
   endtask

   task automatic test_threshold();
      int e;

      e = err_count;
      apply_reset();
      repeat (3)
         src_q[2].push_back(word_t'($random(seed)));
      wait_src_empty();
      repeat (50)
      begin
         step();
         check_count("out_valid", 0, out_valid);
      end
      src_q[2].push_back(word_t'($random(seed)));
      wait_outputs(4);
      check_log();
      finish_test("threshold hold", e);
   endtask

   task automatic test_round_robin();
      int e;

      e = err_count;
      apply_reset();
      rdy_mode = 0;
      for (int c = 0; c < NCH; c++)
         repeat (8)
            src_q[c].push_back(word_t'($random(seed)));
      wait_src_empty();
      repeat (4) step();
      rdy_mode = 1;
      wait_outputs(8 * NCH);
      foreach (got_chan[i])
         check_chan($sformatf("out_chan[%0d]", i), chan_id_t'(i / 4), got_chan[i]);
      check_log();
      finish_test("round robin", e);
   endtask

   task automatic test_backpressure();
      int e;
      int cyc;

      e = err_count;
      apply_reset();
      rdy_mode = 0;
      repeat (`CHAN_AGG_DEPTH + 12)
         src_q[3].push_back(word_t'($random(seed)));
      cyc = 0;
      step();
      while (in_ready[3] && cyc < TIMEOUT)
      begin
         step();
         cyc++;
      end
      if (in_ready[3])
      begin
         $display("Channel 3 never stopped accepting words");
         err_count++;
      end
      repeat (4) step();
      src_q[3].delete();
      check_count("words accepted", `CHAN_AGG_DEPTH + 2, acc_cnt[3]);
      rdy_mode = 1;
      wait_outputs(acc_cnt[3]);
      check_log();
      finish_test("full back-pressure", e);
   endtask

   task automatic test_stress();
      int e;
      int total;
      int n;

      e = err_count;
      apply_reset();
      rdy_mode = 2;
      total = 0;
      for (int c = 0; c < NCH; c++)
      begin
         n = 4 * (1 + ($random(seed) & 7));
         total += n;
         repeat (n)
            src_q[c].push_back(word_t'($random(seed)));
      end
      wait_outputs(total);
      repeat (10) step();
      check_count("output words", total, got_data.size());
      check_log();
      finish_test("random stress", e);
   endtask

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      in_valid   = '0;
      in_data    = '0;
      out_ready  = 1'b0;
      seed       = 32'h4e37_362b;
      err_count  = 0;
      test_count = 0;
      rdy_mode   = 1;
      test_reset();
      test_single();
      test_threshold();
      test_round_robin();
      test_backpressure();
      repeat (3)
         test_stress();
      $display("Tests run %0d, errors %0d", test_count, err_count);
      if (err_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- chan_agg.f
+incdir+hw
hw/chan_agg_pkg.sv
hw/stream_fifo.sv
hw/burst_arbiter.sv
hw/out_stage.sv
hw/chan_agg.sv
verif/chan_agg_tb.sv
